/* filelist.f */
exu_pkg.sv
exu_issue_slot.sv
alu_bru.sv
exu_wb_queue.sv
exu_top.sv
tb_clock_gen.sv
exu_properties.sv
exu_tb.sv

/* Makefile */
# Verilator build and run for the integer execution slice

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* exu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_tb;

    localparam int WB_DEPTH   = 4;
    localparam int CLK_PERIOD = 4;
    localparam int N_DIRECTED = 45;
    localparam int N_RANDOM   = 300;
    localparam int N_OPS      = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_NS = 20 * N_OPS * CLK_PERIOD + 4 * CLK_PERIOD;
    localparam int BP_LEN     = 1024;

    logic                clk;
    logic                rst;
    logic                issue_vld;
    exu_pkg::fu_info_t   issue_info;
    logic                issue_rdy;
    exu_pkg::bypass_t    bypass;
    logic                wb_rdy = 1'b1;
    logic                wb_vld;
    exu_pkg::wb_entry_t  wb_entry;

    integer              seed = 53;
    logic                bp_on = 1'b0;
    logic                bp_pattern [BP_LEN];
    int                  bp_idx = 0;
    logic [5:0]          next_rob = '0;
    int                  n_sent = 0;
    int                  n_checked = 0;
    int                  errors = 0;
    exu_pkg::wb_entry_t  exp_q [$];

    tb_clock_gen #(
        .PERIOD_NS  (CLK_PERIOD),
        .RST_CYCLES (4)
    ) u_clock_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    exu_top #(
        .WB_DEPTH (WB_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .i_issue_vld  (issue_vld),
        .i_issue_info (issue_info),
        .o_issue_rdy  (issue_rdy),
        .o_bypass     (bypass),
        .i_wb_rdy     (wb_rdy),
        .o_wb_vld     (wb_vld),
        .o_wb_entry   (wb_entry)
    );

    bind exu_top exu_properties u_props (
        .clk          (clk),
        .rst          (rst),
        .i_issue_vld  (i_issue_vld),
        .i_issue_info (i_issue_info),
        .i_issue_rdy  (o_issue_rdy),
        .i_bypass     (o_bypass),
        .i_wb_rdy     (i_wb_rdy),
        .i_wb_vld     (o_wb_vld),
        .i_wb_entry   (o_wb_entry),
        .i_stall      (wb_stall),
        .i_finished   (unit_finished),
        .i_entry      (unit_entry)
    );

    // reference model built straight from the RV64 rules
    function automatic exu_pkg::wb_entry_t expected_entry(input exu_pkg::fu_info_t info);
        logic [63:0]         a;
        logic [63:0]         b;
        logic [63:0]         imm64;
        logic [63:0]         res;
        logic [31:0]         w;
        logic                taken;
        exu_pkg::wb_entry_t  e;
        a = info.src0;
        b = info.src1;
        imm64 = 64'($signed(info.imm20));
        res = '0;
        w = '0;
        taken = 1'b0;
        case (info.micop)
            exu_pkg::mop_lui:  res = 64'($signed({info.imm20, 12'h000}));
            exu_pkg::mop_add:  res = a + b;
            exu_pkg::mop_sub:  res = a - b;
            exu_pkg::mop_addw: w = a[31:0] + b[31:0];
            exu_pkg::mop_subw: w = a[31:0] - b[31:0];
            exu_pkg::mop_sll:  res = a << b[5:0];
            exu_pkg::mop_srl:  res = a >> b[5:0];
            exu_pkg::mop_sra:  res = $signed(a) >>> b[5:0];
            exu_pkg::mop_sllw: w = a[31:0] << b[4:0];
            exu_pkg::mop_srlw: w = a[31:0] >> b[4:0];
            exu_pkg::mop_sraw: w = $signed(a[31:0]) >>> b[4:0];
            exu_pkg::mop_xor:  res = a ^ b;
            exu_pkg::mop_or:   res = a | b;
            exu_pkg::mop_and:  res = a & b;
            exu_pkg::mop_slt:  res = 64'($signed(a) < $signed(b));
            exu_pkg::mop_sltu: res = 64'(a < b);
            exu_pkg::mop_jal,
            exu_pkg::mop_jalr: taken = 1'b1;
            exu_pkg::mop_beq:  taken = a == b;
            exu_pkg::mop_bne:  taken = a != b;
            exu_pkg::mop_blt:  taken = $signed(a) < $signed(b);
            exu_pkg::mop_bge:  taken = $signed(a) >= $signed(b);
            exu_pkg::mop_bltu: taken = a < b;
            exu_pkg::mop_bgeu: taken = a >= b;
            default:           res = '0;
        endcase
        // 32 bit results are sign extended from bit 31
        if (info.micop inside {exu_pkg::mop_addw, exu_pkg::mop_subw, exu_pkg::mop_sllw,
                               exu_pkg::mop_srlw, exu_pkg::mop_sraw}) begin
            res = 64'($signed(w));
        end
        e = '0;
        e.comwb.rob_idx = info.rob_idx;
        e.comwb.rd_wen = info.rd_wen;
        e.comwb.prd_idx = info.prd_idx;
        e.comwb.result = info.is_branch ? info.pc + 64'd4 : res;
        e.branch_vld = info.is_branch;
        e.branchwb.rob_idx = info.rob_idx;
        e.branchwb.ftq_idx = info.ftq_idx;
        e.branchwb.taken = taken;
        e.branchwb.fallthru_ofs = info.ftq_ofs + 5'd4;
        e.branchwb.target_pc = (info.micop == exu_pkg::mop_jalr ? a : info.pc) + imm64;
        e.branchwb.npc = taken ? e.branchwb.target_pc : info.pc + 64'd4;
        e.branchwb.mispred = e.branchwb.npc != info.pred_npc;
        // jalr type follows the link register in rd
        case (info.micop)
            exu_pkg::mop_jal:  e.branchwb.branch_type = exu_pkg::br_direct;
            exu_pkg::mop_jalr: e.branchwb.branch_type = (info.prd_idx == 7'd1) ? exu_pkg::br_call :
                                   (info.prd_idx == 7'd0) ? exu_pkg::br_ret : exu_pkg::br_indirect;
            default:           e.branchwb.branch_type = exu_pkg::br_cond;
        endcase
        return e;
    endfunction

    task automatic send_op(input exu_pkg::micop_e op, input logic [63:0] a,
                           input logic [63:0] b, input logic [19:0] imm);
        exu_pkg::fu_info_t   info;
        exu_pkg::wb_entry_t  want;
        logic                took;
        info.micop = op;
        info.is_branch = op >= exu_pkg::mop_jal;
        info.src0 = a;
        info.src1 = b;
        info.pc = {32'($random(seed)), 32'($random(seed))} & ~64'h3;
        info.pred_npc = '0;
        info.imm20 = imm;
        info.rd_wen = 1'($random(seed));
        // small indices on branches reach call, ret and indirect
        info.prd_idx = info.is_branch ? 7'($unsigned($random(seed)) % 3) : 7'($random(seed));
        info.rob_idx = next_rob;
        info.ftq_idx = 4'($random(seed));
        info.ftq_ofs = 5'($random(seed));
        next_rob++;
        want = expected_entry(info);
        // predictor right about half the time
        if ($random(seed) & 1) begin
            info.pred_npc = want.branchwb.npc;
        end else begin
            info.pred_npc = want.branchwb.npc + 64'h8;
        end
        want.branchwb.mispred = want.branchwb.npc != info.pred_npc;
        issue_info = info;
        issue_vld = 1'b1;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = issue_rdy;
            @(posedge clk);
            #1;
        end
        issue_vld = 1'b0;
        exp_q.push_back(want);
        n_sent++;
    endtask

    task automatic check_wb(input exu_pkg::wb_entry_t got);
        exu_pkg::wb_entry_t want;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t: writeback of rob %0d with no op outstanding",
                     $time, got.comwb.rob_idx);
        end else begin
            want = exp_q.pop_front();
            n_checked++;
            assert (got.comwb == want.comwb) else begin
                errors++;
                $display("Error at %0t: rob %0d completion got %h expected %h",
                         $time, want.comwb.rob_idx, got.comwb, want.comwb);
            end
            assert (got.branch_vld == want.branch_vld
                    && (!want.branch_vld || got.branchwb == want.branchwb)) else begin
                errors++;
                $display("Error at %0t: rob %0d branch record got %b/%h expected %b/%h",
                         $time, want.comwb.rob_idx, got.branch_vld, got.branchwb,
                         want.branch_vld, want.branchwb);
            end
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic print_counts();
        $display("records checked %0d of %0d sent, scoreboard errors %0d, assertion failures %0d",
                 n_checked, n_sent, errors, DUT.u_props.fail_cnt);
    endtask

    // handshake completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && wb_vld && wb_rdy) begin
            check_wb(wb_entry);
        end
    end

    always @(posedge clk) begin
        #1;
        wb_rdy = bp_on ? bp_pattern[bp_idx] : 1'b1;
        bp_idx = (bp_idx + 1) % BP_LEN;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with %0d records outstanding",
                 TIMEOUT_NS, exp_q.size());
        print_counts();
        $display("Test failed");
        $finish;
    end

    initial begin
        exu_pkg::micop_e  op;
        logic [63:0]      a;
        logic [63:0]      b;
        issue_vld = 1'b0;
        issue_info = '0;
        for (int i = 0; i < BP_LEN; i++) begin
            bp_pattern[i] = 1'($random(seed));
        end
        @(negedge rst);
        @(posedge clk);
        #1;

        // alu corner cases with the consumer always ready
        send_op(exu_pkg::mop_lui, 64'd0, 64'd0, 20'h80001);
        send_op(exu_pkg::mop_add, 64'h7fff_ffff_ffff_ffff, 64'd1, 20'h0);
        send_op(exu_pkg::mop_sub, 64'd0, 64'd1, 20'h0);
        send_op(exu_pkg::mop_addw, 64'h0000_0000_7fff_ffff, 64'd1, 20'h0);
        send_op(exu_pkg::mop_subw, 64'h0000_0001_0000_0000, 64'd1, 20'h0);
        send_op(exu_pkg::mop_sll, 64'h8000_0000_0000_0001, 64'd0, 20'h0);
        send_op(exu_pkg::mop_sll, 64'h8000_0000_0000_0001, 64'd63, 20'h0);
        send_op(exu_pkg::mop_srl, 64'h8000_0000_0000_0001, 64'd0, 20'h0);
        send_op(exu_pkg::mop_srl, 64'h8000_0000_0000_0001, 64'd63, 20'h0);
        send_op(exu_pkg::mop_sra, 64'h8000_0000_0000_0001, 64'd0, 20'h0);
        send_op(exu_pkg::mop_sra, 64'h8000_0000_0000_0001, 64'd63, 20'h0);
        send_op(exu_pkg::mop_sllw, 64'd1, 64'd31, 20'h0);
        send_op(exu_pkg::mop_srlw, 64'hffff_ffff_8000_0000, 64'd0, 20'h0);
        send_op(exu_pkg::mop_sraw, 64'hffff_ffff_8000_0000, 64'd31, 20'h0);
        send_op(exu_pkg::mop_xor, 64'h0f0f_0f0f_f0f0_f0f0, 64'hff00_ff00_ff00_ff00, 20'h0);
        send_op(exu_pkg::mop_or, 64'h0f0f_0f0f_f0f0_f0f0, 64'hff00_ff00_ff00_ff00, 20'h0);
        send_op(exu_pkg::mop_and, 64'h0f0f_0f0f_f0f0_f0f0, 64'hff00_ff00_ff00_ff00, 20'h0);
        send_op(exu_pkg::mop_slt, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 20'h0);
        send_op(exu_pkg::mop_sltu, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 20'h0);
        send_op(exu_pkg::mop_slt, 64'h7fff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 20'h0);
        send_op(exu_pkg::mop_sltu, 64'd1, 64'hffff_ffff_ffff_ffff, 20'h0);
        drain();

        // each branch op with equal, signed-split and unsigned-split operands
        for (int k = int'(exu_pkg::mop_jal); k <= int'(exu_pkg::mop_bgeu); k++) begin
            op = exu_pkg::micop_e'(k);
            send_op(op, 64'h55, 64'h55, 20'($random(seed)));
            send_op(op, 64'hffff_ffff_ffff_fff0, 64'h10, 20'($random(seed)));
            send_op(op, 64'h10, 64'hffff_ffff_ffff_fff0, 20'($random(seed)));
        end
        drain();

        // random mix under random back-pressure
        bp_on = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            op = exu_pkg::micop_e'(5'($unsigned($random(seed)) % 24));
            a = {32'($random(seed)), 32'($random(seed))};
            b = {32'($random(seed)), 32'($random(seed))};
            if (($random(seed) & 3) == 0) begin
                b = a;
            end
            if (($random(seed) & 7) == 0) begin
                @(posedge clk);
                #1;
            end
            send_op(op, a, b, 20'($random(seed)));
        end
        drain();
        repeat (4) @(posedge clk);

        print_counts();
        if (errors == 0 && DUT.u_props.fail_cnt == 0 && n_checked == n_sent) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exu_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_properties (
    input wire                      clk,
    input wire                      rst,
    input wire                      i_issue_vld,
    input wire exu_pkg::fu_info_t   i_issue_info,
    input wire                      i_issue_rdy,
    input wire exu_pkg::bypass_t    i_bypass,
    input wire                      i_wb_rdy,
    input wire                      i_wb_vld,
    input wire exu_pkg::wb_entry_t  i_wb_entry,
    input wire                      i_stall,
    input wire                      i_finished,
    input wire exu_pkg::wb_entry_t  i_entry
);

    int unsigned fail_cnt = 0;
    logic        accept;

    assign accept = i_issue_vld && i_issue_rdy;

    // idle outputs in the cycle after any reset edge
    reset_state: assert property (@(posedge clk)
        rst |=> (!i_wb_vld && !i_bypass.vld && i_issue_rdy))
    else begin
        fail_cnt++;
        $error("outputs not idle after reset");
    end

    // empty queue and a ready consumer give the 3 cycle path
    wb_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(accept, 4) && !$past(i_wb_vld, 4) && $past(i_wb_rdy, 4)
            && $past(i_wb_rdy, 3) && $past(i_wb_rdy, 2) && $past(i_wb_rdy, 1))
        |-> (i_wb_vld && i_wb_entry.comwb.rob_idx == $past(i_issue_info.rob_idx, 4)))
    else begin
        fail_cnt++;
        $error("writeback did not appear 3 cycles after issue");
    end

    wb_hold: assert property (@(posedge clk) disable iff (rst)
        (i_wb_vld && !i_wb_rdy) |=> (i_wb_vld && $stable(i_wb_entry)))
    else begin
        fail_cnt++;
        $error("writeback head changed while the consumer was not ready");
    end

    // bypass matches the record registered on the next edge
    bypass_match: assert property (@(posedge clk) disable iff (rst)
        i_bypass.vld |=> (i_finished && i_entry.comwb.rd_wen
            && i_entry.comwb.prd_idx == $past(i_bypass.prd_idx)
            && i_entry.comwb.result == $past(i_bypass.data)))
    else begin
        fail_cnt++;
        $error("bypass does not match the completion record");
    end

    // a freshly registered record had a bypass exactly when it writes rd
    bypass_only_rd: assert property (@(posedge clk) disable iff (rst)
        ($past(!i_stall) && i_finished) |-> ($past(i_bypass.vld) == i_entry.comwb.rd_wen))
    else begin
        fail_cnt++;
        $error("bypass valid disagrees with rd write enable");
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset released 1 ns after a rising edge
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst = 1'b0;
    end

endmodule

`default_nettype wire

/* exu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_top #(
    parameter int WB_DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      rst,

    // issue
    input  wire                      i_issue_vld,
    input  wire exu_pkg::fu_info_t   i_issue_info,
    output logic                     o_issue_rdy,

    // early bypass
    output exu_pkg::bypass_t         o_bypass,

    // writeback
    input  wire                      i_wb_rdy,
    output logic                     o_wb_vld,
    output exu_pkg::wb_entry_t       o_wb_entry
);

    logic                slot_vld;
    exu_pkg::fu_info_t   slot_info;
    logic                wb_stall;
    logic                unit_finished;
    exu_pkg::wb_entry_t  unit_entry;

    exu_issue_slot u_issue_slot (
        .clk          (clk),
        .rst          (rst),
        .i_issue_vld  (i_issue_vld),
        .i_issue_info (i_issue_info),
        .i_stall      (wb_stall),
        .o_issue_rdy  (o_issue_rdy),
        .o_vld        (slot_vld),
        .o_info       (slot_info)
    );

    alu_bru u_alu_bru (
        .clk        (clk),
        .rst        (rst),
        .i_vld      (slot_vld),
        .i_info     (slot_info),
        .i_stall    (wb_stall),
        .o_bypass   (o_bypass),
        .o_finished (unit_finished),
        .o_entry    (unit_entry)
    );

    // stall from the queue freezes the slot and both unit stages
    exu_wb_queue #(
        .WB_DEPTH (WB_DEPTH)
    ) u_wb_queue (
        .clk        (clk),
        .rst        (rst),
        .i_push     (unit_finished),
        .i_entry    (unit_entry),
        .i_wb_rdy   (i_wb_rdy),
        .o_stall    (wb_stall),
        .o_wb_vld   (o_wb_vld),
        .o_wb_entry (o_wb_entry)
    );

endmodule

`default_nettype wire

/* exu_wb_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_wb_queue #(
    parameter int WB_DEPTH = 4
) (
    input  wire                      clk,
    input  wire                      rst,

    // from the unit output register
    input  wire                      i_push,
    input  wire exu_pkg::wb_entry_t  i_entry,
    output logic                     o_stall,

    // to the consumer
    input  wire                      i_wb_rdy,
    output logic                     o_wb_vld,
    output exu_pkg::wb_entry_t       o_wb_entry
);

    localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
    localparam int CNT_W = $clog2(WB_DEPTH + 1);

    exu_pkg::wb_entry_t  mem [WB_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [CNT_W-1:0]    count_after_pop;
    logic                push_en;
    logic                pop_en;

    assign pop_en  = o_wb_vld && i_wb_rdy;
    assign push_en = i_push && !o_stall;

    // stall on the count left after this pop keeps one slot spare
    assign count_after_pop = count - CNT_W'(pop_en);
    assign o_stall         = count_after_pop >= CNT_W'(WB_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_en && !pop_en) begin
                count <= count + 1'b1;
            end else if (pop_en && !push_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr] <= i_entry;
        end
    end

    // head shows through without a read cycle
    assign o_wb_vld   = count != '0;
    assign o_wb_entry = mem[rd_ptr];

endmodule

`default_nettype wire

/* alu_bru.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_bru (
    input  wire                     clk,
    input  wire                     rst,

    // offered op
    input  wire                     i_vld,
    input  wire exu_pkg::fu_info_t  i_info,
    input  wire                     i_stall,

    // early bypass
    output exu_pkg::bypass_t        o_bypass,

    // writeback
    output logic                    o_finished,
    output exu_pkg::wb_entry_t      o_entry
);

    logic                        s1_vld;
    exu_pkg::fu_info_t           s1_info;
    logic [exu_pkg::XLEN-1:0]    src0;
    logic [exu_pkg::XLEN-1:0]    src1;
    logic [exu_pkg::XLEN-1:0]    imm_sext;
    logic [exu_pkg::XLEN-1:0]    sum;
    logic [exu_pkg::XLEN-1:0]    diff;
    logic [5:0]                  shamt;
    logic [4:0]                  shamt_w;
    logic [31:0]                 sllw_lo;
    logic [31:0]                 srlw_lo;
    logic [31:0]                 sraw_lo;
    logic                        lt_s;
    logic                        lt_u;
    logic [exu_pkg::XLEN-1:0]    alu_res;
    logic [exu_pkg::XLEN-1:0]    fallthru;
    logic [exu_pkg::XLEN-1:0]    target;
    logic [exu_pkg::XLEN-1:0]    npc;
    logic                        taken;
    logic                        mispred;
    exu_pkg::branch_type_e       br_type;
    logic [exu_pkg::XLEN-1:0]    wb_result;

    // stage 1 capture
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (!i_stall) begin
            s1_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            s1_info <= i_info;
        end
    end

    assign src0     = s1_info.src0;
    assign src1     = s1_info.src1;
    assign imm_sext = {{(exu_pkg::XLEN-20){s1_info.imm20[19]}}, s1_info.imm20};
    assign sum      = src0 + src1;
    assign diff     = src0 - src1;
    assign shamt    = src1[5:0];
    assign shamt_w  = src1[4:0];

    // word shifts only see the low half of rs1
    assign sllw_lo = src0[31:0] << shamt_w;
    assign srlw_lo = src0[31:0] >> shamt_w;
    assign sraw_lo = $signed(src0[31:0]) >>> shamt_w;

    assign lt_s = $signed(src0) < $signed(src1);
    assign lt_u = src0 < src1;

    always_comb begin
        alu_res = '0;
        case (s1_info.micop)
            exu_pkg::mop_lui:  alu_res = {{32{s1_info.imm20[19]}}, s1_info.imm20, 12'd0};
            exu_pkg::mop_add:  alu_res = sum;
            exu_pkg::mop_sub:  alu_res = diff;
            exu_pkg::mop_addw: alu_res = {{32{sum[31]}}, sum[31:0]};
            exu_pkg::mop_subw: alu_res = {{32{diff[31]}}, diff[31:0]};
            exu_pkg::mop_sll:  alu_res = src0 << shamt;
            exu_pkg::mop_srl:  alu_res = src0 >> shamt;
            exu_pkg::mop_sra:  alu_res = $signed(src0) >>> shamt;
            exu_pkg::mop_sllw: alu_res = {{32{sllw_lo[31]}}, sllw_lo};
            exu_pkg::mop_srlw: alu_res = {{32{srlw_lo[31]}}, srlw_lo};
            exu_pkg::mop_sraw: alu_res = {{32{sraw_lo[31]}}, sraw_lo};
            exu_pkg::mop_xor:  alu_res = src0 ^ src1;
            exu_pkg::mop_or:   alu_res = src0 | src1;
            exu_pkg::mop_and:  alu_res = src0 & src1;
            exu_pkg::mop_slt:  alu_res = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
            exu_pkg::mop_sltu: alu_res = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
            default:           alu_res = '0;
        endcase
    end

    // branch resolution
    always_comb begin
        taken = 1'b0;
        case (s1_info.micop)
            exu_pkg::mop_jal,
            exu_pkg::mop_jalr: taken = 1'b1;
            exu_pkg::mop_beq:  taken = src0 == src1;
            exu_pkg::mop_bne:  taken = src0 != src1;
            exu_pkg::mop_blt:  taken = lt_s;
            exu_pkg::mop_bge:  taken = !lt_s;
            exu_pkg::mop_bltu: taken = lt_u;
            exu_pkg::mop_bgeu: taken = !lt_u;
            default:           taken = 1'b0;
        endcase
    end

    assign fallthru = s1_info.pc + exu_pkg::XLEN'(4);
    assign target   = ((s1_info.micop == exu_pkg::mop_jalr) ? src0 : s1_info.pc) + imm_sext;
    assign npc      = taken ? target : fallthru;
    assign mispred  = npc != s1_info.pred_npc;

    // link register convention on the destination index
    always_comb begin
        if (s1_info.micop == exu_pkg::mop_jalr && s1_info.prd_idx == exu_pkg::PRF_IDX_W'(1)) begin
            br_type = exu_pkg::br_call;
        end else if (s1_info.micop == exu_pkg::mop_jalr && s1_info.prd_idx == '0) begin
            br_type = exu_pkg::br_ret;
        end else if (s1_info.micop == exu_pkg::mop_jalr) begin
            br_type = exu_pkg::br_indirect;
        end else if (s1_info.micop == exu_pkg::mop_jal) begin
            br_type = exu_pkg::br_direct;
        end else begin
            br_type = exu_pkg::br_cond;
        end
    end

    // jumps write the return address
    assign wb_result = s1_info.is_branch ? fallthru : alu_res;

    // only while the op really moves on to stage 2
    assign o_bypass = '{
        vld:     s1_vld && s1_info.rd_wen && !i_stall,
        prd_idx: s1_info.prd_idx,
        data:    wb_result
    };

    // stage 2 output register
    always_ff @(posedge clk) begin
        if (rst) begin
            o_finished <= 1'b0;
        end else if (!i_stall) begin
            o_finished <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_entry.comwb <= '{
                rob_idx: s1_info.rob_idx,
                rd_wen:  s1_info.rd_wen,
                prd_idx: s1_info.prd_idx,
                result:  wb_result
            };
            o_entry.branch_vld <= s1_info.is_branch;
            o_entry.branchwb <= '{
                branch_type:  br_type,
                rob_idx:      s1_info.rob_idx,
                ftq_idx:      s1_info.ftq_idx,
                mispred:      mispred,
                taken:        taken,
                fallthru_ofs: s1_info.ftq_ofs + exu_pkg::FTQ_OFS_W'(4),
                target_pc:    target,
                npc:          npc
            };
        end
    end

endmodule

`default_nettype wire

/* exu_issue_slot.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_issue_slot (
    input  wire                     clk,
    input  wire                     rst,

    // issue queue side
    input  wire                     i_issue_vld,
    input  wire exu_pkg::fu_info_t  i_issue_info,
    output logic                    o_issue_rdy,

    // unit side
    input  wire                     i_stall,
    output logic                    o_vld,
    output exu_pkg::fu_info_t       o_info
);

    logic               main_vld;
    exu_pkg::fu_info_t  main_info;
    logic               skid_vld;
    exu_pkg::fu_info_t  skid_info;
    logic               accept;
    logic               main_free;

    // ready only depends on the skid flop, so it never follows stall
    assign o_issue_rdy = !skid_vld;
    assign accept      = i_issue_vld && !skid_vld;

    // main slot empty, or its op is taken by the unit this cycle
    assign main_free = !main_vld || !i_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_vld <= 1'b0;
            skid_vld <= 1'b0;
        end else if (main_free) begin
            if (skid_vld) begin
                // older op moves up while ready is still low
                main_vld <= 1'b1;
                skid_vld <= 1'b0;
            end else begin
                main_vld <= accept;
            end
        end else if (accept) begin
            skid_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_vld) begin
                main_info <= skid_info;
            end else if (accept) begin
                main_info <= i_issue_info;
            end
        end else if (accept) begin
            skid_info <= i_issue_info;
        end
    end

    // oldest held op is always in main
    assign o_vld  = main_vld;
    assign o_info = main_info;

endmodule

`default_nettype wire

/* exu_pkg.sv */
`default_nettype none

package exu_pkg;

    // architectural and core sizing
    localparam int XLEN      = 64;
    localparam int PRF_IDX_W = 7;
    localparam int ROB_IDX_W = 6;
    localparam int FTQ_IDX_W = 4;
    localparam int FTQ_OFS_W = 5;

    // alu ops first, branch ops after
    typedef enum logic [4:0] {
        mop_lui,  mop_add,  mop_sub,  mop_addw,
        mop_subw, mop_sll,  mop_srl,  mop_sra,
        mop_sllw, mop_srlw, mop_sraw, mop_xor,
        mop_or,   mop_and,  mop_slt,  mop_sltu,
        mop_jal,  mop_jalr, mop_beq,  mop_bne,
        mop_blt,  mop_bge,  mop_bltu, mop_bgeu
    } micop_e;

    typedef enum logic [2:0] {
        br_cond,
        br_direct,
        br_indirect,
        br_call,
        br_ret
    } branch_type_e;

    // one issued micro-op
    typedef struct packed {
        micop_e                micop;
        logic                  is_branch;
        logic [XLEN-1:0]       src0;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pred_npc;
        logic [19:0]           imm20;
        logic                  rd_wen;
        logic [PRF_IDX_W-1:0]  prd_idx;
        logic [ROB_IDX_W-1:0]  rob_idx;
        logic [FTQ_IDX_W-1:0]  ftq_idx;
        logic [FTQ_OFS_W-1:0]  ftq_ofs;
    } fu_info_t;

    // completion record
    typedef struct packed {
        logic [ROB_IDX_W-1:0]  rob_idx;
        logic                  rd_wen;
        logic [PRF_IDX_W-1:0]  prd_idx;
        logic [XLEN-1:0]       result;
    } comwb_info_t;

    // branch resolution record
    typedef struct packed {
        branch_type_e          branch_type;
        logic [ROB_IDX_W-1:0]  rob_idx;
        logic [FTQ_IDX_W-1:0]  ftq_idx;
        logic                  mispred;
        logic                  taken;
        logic [FTQ_OFS_W-1:0]  fallthru_ofs;
        logic [XLEN-1:0]       target_pc;
        logic [XLEN-1:0]       npc;
    } branchwb_info_t;

    typedef struct packed {
        comwb_info_t           comwb;
        logic                  branch_vld;
        branchwb_info_t        branchwb;
    } wb_entry_t;

    typedef struct packed {
        logic                  vld;
        logic [PRF_IDX_W-1:0]  prd_idx;
        logic [XLEN-1:0]       data;
    } bypass_t;

endpackage

`default_nettype wire
